/* Bender.yml */
package:
  name: vec_front

sources:
  - vec_front_pkg.sv
  - vec_issue_decoder.sv
  - vec_ring_buffer.sv
  - vec_dispatcher.sv
  - vec_front.sv
  - target: test
    files:
      - tb_vec_front.sv

/* all.f */
vec_front_pkg.sv
vec_issue_decoder.sv
vec_ring_buffer.sv
vec_dispatcher.sv
vec_front.sv
tb_vec_front.sv

/* tb_vec_front.sv */
// Self-checking testbench for vec_front; assumes in-order commit and no more than 16 live ids
`timescale 1ns/1ps

module tb_vec_front;

  localparam int unsigned ClkPeriod = 100;
  localparam int unsigned NumCfg    = 30;
  // Upper bound on instructions issued by all phases
  localparam int unsigned NumOps    = NumCfg * 3 + 30;

  typedef struct packed {
    logic                    is_cfg;
    vec_front_pkg::result_t  res;
    vec_front_pkg::vec_req_t req;
  } expect_t;

  typedef struct packed {
    vec_front_pkg::id_t   id;
    vec_front_pkg::xlen_t rs1;
    vec_front_pkg::xlen_t rs2;
    logic [1:0]           delay;
  } opnd_t;

  logic                       clk_i;
  logic                       rst_ni;
  vec_front_pkg::issue_req_t  issue_req_i;
  logic                       issue_ready_o;
  vec_front_pkg::issue_resp_t issue_resp_o;
  vec_front_pkg::commit_t     commit_i;
  vec_front_pkg::reg_t        reg_i;
  vec_front_pkg::result_t     result_o;
  logic                       vec_req_valid_o;
  vec_front_pkg::vec_req_t    vec_req_o;
  logic                       vec_req_ready_i;

  logic [31:0]                rng_state = 32'd70;
  expect_t                    exp_q[$];
  opnd_t                      opnd_q[$];
  int unsigned                commit_pending;
  logic                       kill_req;
  logic                       cfg_outstanding;
  logic                       hold_ready_low;
  vec_front_pkg::id_t         next_id;
  vec_front_pkg::vl_t         model_vl;
  vec_front_pkg::sew_e        model_sew;

  vec_front vec_front_inst (
    .clk_i          (clk_i          ),
    .rst_ni         (rst_ni         ),
    .issue_req_i    (issue_req_i    ),
    .issue_ready_o  (issue_ready_o  ),
    .issue_resp_o   (issue_resp_o   ),
    .commit_i       (commit_i       ),
    .reg_i          (reg_i          ),
    .result_o       (result_o       ),
    .vec_req_valid_o(vec_req_valid_o),
    .vec_req_o      (vec_req_o      ),
    .vec_req_ready_i(vec_req_ready_i)
  );

  initial begin : clock_gen
    clk_i = 1'b0;
    forever begin
      #(ClkPeriod / 2) clk_i = ~clk_i;
    end
  end

  ////////////////////////////////////////////////////////////
  // Helpers and reference model
  ////////////////////////////////////////////////////////////

  function automatic logic [31:0] next_random();
    logic [31:0] x;
    x = rng_state;
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    rng_state = x;
    return x;
  endfunction

  // Mix of short AVLs around VLMAX and huge ones
  function automatic logic [31:0] random_avl();
    if (next_random() & 1) begin
      return next_random() % 48;
    end
    return next_random();
  endfunction

  function automatic vec_front_pkg::vl_t ref_vl(logic [31:0] avl, vec_front_pkg::sew_e sew);
    int unsigned vlmax;
    vlmax = vec_front_pkg::VLen / (8 << int'(sew));
    return (avl < vlmax) ? vec_front_pkg::vl_t'(avl) : vec_front_pkg::vl_t'(vlmax);
  endfunction

  function automatic logic [31:0] illegal_instr(int unsigned k);
    case (k % 4)
      0:       return 32'h8000_7057; // vsetvl form, bit 31 set
      1:       return 32'h0000_1057; // OPFVV
      2:       return 32'h0000_0033; // scalar add
      default: return 32'h9400_0057; // vmul funct6 under OPIVV
    endcase
  endfunction

  task automatic stop_with_failure(string what);
    $display("%s", what);
    $display("TEST FAILED");
    $fatal(1);
  endtask

  task automatic check_field(string name, logic [63:0] got, logic [63:0] want);
    assert (got === want)
    else stop_with_failure($sformatf("FAILED at %0t ns: %s = 0x%0h, expected 0x%0h",
                                     $time, name, got, want));
  endtask

  // Starts at a falling edge, returns on the falling edge after acceptance
  task automatic offer(logic [31:0] instr, logic is_cfg, logic [31:0] rs1, logic keep,
                       expect_t want);
    opnd_t opnd;
    issue_req_i = '{valid: 1'b1, instr: instr, id: next_id};
    do begin
      @(posedge clk_i);
    end while (!issue_ready_o);
    assert (issue_resp_o.accept && issue_resp_o.writeback == is_cfg)
    else stop_with_failure("A legal instruction was not accepted with the right writeback");
    if (keep) begin
      exp_q.push_back(want);
      commit_pending++;
    end
    opnd = '{id: next_id, rs1: rs1, rs2: next_random(), delay: 2'(1 + next_random() % 3)};
    opnd_q.push_back(opnd);
    next_id++;
    @(negedge clk_i);
    issue_req_i.valid = 1'b0;
    if (is_cfg) begin
      cfg_outstanding = 1'b1;
    end
  endtask

  task automatic send_vsetvli(logic [31:0] avl, vec_front_pkg::sew_e sew, logic [4:0] rd,
                              logic keep);
    expect_t     want;
    logic [31:0] instr;
    instr       = {1'b0, 6'b0, sew, 3'b0, 5'd1, 3'b111, rd, 7'b1010111};
    want        = '0;
    want.is_cfg = 1'b1;
    want.res    = '{valid: 1'b1, id: next_id, rd: rd,
                    data: vec_front_pkg::xlen_t'(ref_vl(avl, sew))};
    if (keep) begin
      model_vl  = ref_vl(avl, sew);
      model_sew = sew;
    end
    offer(instr, 1'b1, avl, keep, want);
  endtask

  task automatic send_random_arith(logic keep);
    expect_t     want;
    logic [31:0] r, rs1, instr;
    r     = next_random();
    rs1   = next_random();
    instr = r[0] ? {6'd37, 1'b1, r[15:11], r[10:6], 3'b010, r[5:1], 7'b1010111} :
                   {6'd0, 1'b1, r[15:11], r[10:6], 3'b000, r[5:1], 7'b1010111};
    want     = '0;
    want.req = '{op: r[0] ? vec_front_pkg::OpVmul : vec_front_pkg::OpVadd, vd: r[5:1],
                 vs1: r[10:6], vs2: r[15:11], vl: model_vl, sew: model_sew, rs1: rs1};
    offer(instr, 1'b0, rs1, keep, want);
  endtask

  task automatic send_illegal(logic [31:0] instr);
    issue_req_i = '{valid: 1'b1, instr: instr, id: next_id};
    @(posedge clk_i);
    assert (!issue_resp_o.accept)
    else stop_with_failure("An illegal instruction was accepted");
    @(negedge clk_i);
    issue_req_i.valid = 1'b0;
  endtask

  task automatic drain();
    while (exp_q.size() != 0) begin
      @(posedge clk_i);
    end
    @(negedge clk_i);
  endtask

  ////////////////////////////////////////////////////////////
  // Core and sink models, driven on falling edges
  ////////////////////////////////////////////////////////////

  always @(negedge clk_i) begin : core_model
    int idx;
    idx      = -1;
    commit_i = '0;
    reg_i    = '0;
    if (kill_req) begin
      commit_i        = '{valid: 1'b1, kill: 1'b1};
      kill_req        = 1'b0;
      commit_pending  = 0;
      cfg_outstanding = 1'b0;
      opnd_q.delete();
    end else if (commit_pending > 0 && (next_random() & 1)) begin
      commit_i = '{valid: 1'b1, kill: 1'b0};
      commit_pending--;
    end
    foreach (opnd_q[i]) begin
      if (opnd_q[i].delay > 0) begin
        opnd_q[i].delay--;
      end
      if (idx < 0 && opnd_q[i].delay == 0) begin
        idx = i;
      end
    end
    if (idx >= 0) begin
      reg_i = '{valid: 1'b1, id: opnd_q[idx].id, rs1: opnd_q[idx].rs1, rs2: opnd_q[idx].rs2};
      opnd_q.delete(idx);
    end
  end

  always @(negedge clk_i) begin : sink_ready
    vec_req_ready_i = !hold_ready_low && ((next_random() & 3) != 0);
  end

  always @(posedge clk_i) begin : compare
    expect_t want;
    if (cfg_outstanding) begin
      assert (!issue_ready_o)
      else stop_with_failure("issue_ready was high while a vsetvli result was pending");
    end
    if (result_o.valid) begin
      assert (exp_q.size() > 0 && exp_q[0].is_cfg)
      else stop_with_failure("A result appeared with no vsetvli pending");
      want = exp_q.pop_front();
      check_field("result_o.id", result_o.id, want.res.id);
      check_field("result_o.rd", result_o.rd, want.res.rd);
      check_field("result_o.data", result_o.data, want.res.data);
      cfg_outstanding = 1'b0;
    end
    if (vec_req_valid_o && vec_req_ready_i) begin
      assert (exp_q.size() > 0 && !exp_q[0].is_cfg)
      else stop_with_failure("A vector request appeared with no vector instruction pending");
      want = exp_q.pop_front();
      check_field("vec_req_o.op", vec_req_o.op, want.req.op);
      check_field("vec_req_o.vd", vec_req_o.vd, want.req.vd);
      check_field("vec_req_o.vs1", vec_req_o.vs1, want.req.vs1);
      check_field("vec_req_o.vs2", vec_req_o.vs2, want.req.vs2);
      check_field("vec_req_o.vl", vec_req_o.vl, want.req.vl);
      check_field("vec_req_o.sew", vec_req_o.sew, want.req.sew);
      check_field("vec_req_o.rs1", vec_req_o.rs1, want.req.rs1);
    end
  end

  initial begin : watchdog
    #(NumOps * 40 * ClkPeriod);
    stop_with_failure($sformatf("Timeout: the run did not finish within %0d cycles",
                                NumOps * 40));
  end

  ////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////

  initial begin : stimulus
    logic [31:0] r;
    rst_ni          = 1'b0;
    issue_req_i     = '0;
    commit_i        = '0;
    reg_i           = '0;
    vec_req_ready_i = 1'b0;
    commit_pending  = 0;
    kill_req        = 1'b0;
    cfg_outstanding = 1'b0;
    hold_ready_low  = 1'b0;
    next_id         = '0;
    model_vl        = '0;
    model_sew       = vec_front_pkg::Sew8;
    repeat (8) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    @(posedge clk_i);
    assert (issue_ready_o && !vec_req_valid_o && !result_o.valid)
    else stop_with_failure("Outputs were not idle after reset");
    @(negedge clk_i);

    // Random vsetvli mixed with arithmetic and the odd illegal word
    for (int i = 0; i < NumCfg; i++) begin
      r = next_random();
      send_vsetvli(random_avl(), vec_front_pkg::sew_e'(r[1:0]), r[6:2], 1'b1);
      for (int k = 0; k < int'(r[9:8] % 3); k++) begin
        send_random_arith(1'b1);
      end
      if (i % 8 == 3) begin
        send_illegal(illegal_instr(i / 8));
      end
    end

    // Uncommitted work, then a kill
    drain();
    for (int k = 0; k < 3; k++) begin
      send_random_arith(1'b0);
    end
    send_vsetvli(random_avl(), vec_front_pkg::Sew32, 5'd7, 1'b0);
    repeat (4) @(posedge clk_i);
    kill_req = 1'b1;
    @(negedge clk_i);
    @(negedge clk_i);
    send_vsetvli(random_avl(), vec_front_pkg::Sew16, 5'd3, 1'b1);
    for (int k = 0; k < 3; k++) begin
      send_random_arith(1'b1);
    end

    // Back-pressure fills the buffer
    drain();
    @(posedge clk_i);
    hold_ready_low = 1'b1;
    @(negedge clk_i);
    for (int k = 0; k < 9; k++) begin
      send_random_arith(1'b1);
    end
    repeat (30) begin
      @(posedge clk_i);
      if (!issue_ready_o) break;
    end
    assert (!issue_ready_o)
    else stop_with_failure("issue_ready stayed high while vec_req_ready was held low");
    repeat (20) @(posedge clk_i);
    hold_ready_low = 1'b0;
    @(negedge clk_i);
    for (int k = 0; k < 4; k++) begin
      send_random_arith(1'b1);
    end
    drain();
    // Quiet tail catches any stray output
    repeat (5) @(posedge clk_i);

    $display("TEST PASSED");
    $finish;
  end

endmodule

/* vec_dispatcher.sv */
// Holds vl and vtype; vl is min(rs1, VLen/SEW) with no x0 special case, LMUL fixed at 1
`timescale 1ns/1ps

module vec_dispatcher (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      head_valid_i,
  input  vec_front_pkg::buf_entry_t head_i,
  output logic                      head_ready_o,
  output logic                      vsetvli_done_o,
  output vec_front_pkg::result_t    result_o,
  output logic                      vec_req_valid_o,
  output vec_front_pkg::vec_req_t   vec_req_o,
  input  logic                      vec_req_ready_i
);

  // Fall-through register
  logic                      ft_valid_q;
  vec_front_pkg::buf_entry_t ft_data_q;
  logic                      item_valid;
  vec_front_pkg::buf_entry_t item;
  logic                      item_is_cfg, item_is_vec;
  logic                      consume;
  // CSR state and result
  vec_front_pkg::vl_t        vl_q, new_vl;
  vec_front_pkg::sew_e       sew_q;
  logic                      res_valid_q;
  vec_front_pkg::id_t        res_id_q;
  vec_front_pkg::reg_idx_t   res_rd_q;

  function automatic vec_front_pkg::vl_t vlmax(vec_front_pkg::sew_e sew);
    vec_front_pkg::vl_t max_vl;
    unique case (sew)
      vec_front_pkg::Sew8:  max_vl = vec_front_pkg::vl_t'(vec_front_pkg::VLen / 8);
      vec_front_pkg::Sew16: max_vl = vec_front_pkg::vl_t'(vec_front_pkg::VLen / 16);
      vec_front_pkg::Sew32: max_vl = vec_front_pkg::vl_t'(vec_front_pkg::VLen / 32);
      default:              max_vl = vec_front_pkg::vl_t'(vec_front_pkg::VLen / 64);
    endcase
    return max_vl;
  endfunction

  ////////////////////////////////////////////////////////////
  // Item selection
  ////////////////////////////////////////////////////////////

  // Empty register lets the head straight through
  assign item_valid   = ft_valid_q || head_valid_i;
  assign item         = ft_valid_q ? ft_data_q : head_i;
  assign head_ready_o = !ft_valid_q;

  assign item_is_cfg = (item.op == vec_front_pkg::OpVsetvli);
  assign item_is_vec = (item.op == vec_front_pkg::OpVadd) || (item.op == vec_front_pkg::OpVmul);

  // vsetvli never waits
  assign consume = item_valid && (item_is_cfg || vec_req_ready_i);

  assign new_vl = (item.rs1 < vec_front_pkg::xlen_t'(vlmax(item.sew))) ?
                  vec_front_pkg::vl_t'(item.rs1) : vlmax(item.sew);

  always_ff @(posedge clk_i or negedge rst_ni) begin : ft_ctrl
    if (!rst_ni) begin
      ft_valid_q <= 1'b0;
    end else if (ft_valid_q) begin
      if (consume) begin
        ft_valid_q <= 1'b0;
      end
    end else if (head_valid_i && !consume) begin
      ft_valid_q <= 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin : ft_data
    if (!ft_valid_q && head_valid_i) begin
      ft_data_q <= head_i;
    end
  end

  ////////////////////////////////////////////////////////////
  // CSRs and outputs
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin : csr_regs
    if (!rst_ni) begin
      vl_q        <= '0;
      sew_q       <= vec_front_pkg::Sew8;
      res_valid_q <= 1'b0;
    end else begin
      res_valid_q <= consume && item_is_cfg;
      if (consume && item_is_cfg) begin
        vl_q  <= new_vl;
        sew_q <= item.sew;
      end
    end
  end

  always_ff @(posedge clk_i) begin : result_payload
    if (consume && item_is_cfg) begin
      res_id_q <= item.id;
      res_rd_q <= item.rd;
    end
  end

  // vl_q already holds the new value while the result is up
  assign result_o       = '{valid: res_valid_q, id: res_id_q, rd: res_rd_q,
                            data: vec_front_pkg::xlen_t'(vl_q)};
  assign vsetvli_done_o = res_valid_q;

  assign vec_req_valid_o = item_valid && item_is_vec;
  assign vec_req_o       = '{op: item.op, vd: item.rd, vs1: item.vs1, vs2: item.vs2,
                             vl: vl_q, sew: sew_q, rs1: item.rs1};

endmodule

/* vec_front.sv */
// Vector issue front end; in-order commit only, result pulse has no back-pressure
`timescale 1ns/1ps

module vec_front (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  // Issue
  input  vec_front_pkg::issue_req_t  issue_req_i,
  output logic                       issue_ready_o,
  output vec_front_pkg::issue_resp_t issue_resp_o,
  // Commit and operands
  input  vec_front_pkg::commit_t     commit_i,
  input  vec_front_pkg::reg_t        reg_i,
  // Outputs to the core and the vector unit
  output vec_front_pkg::result_t     result_o,
  output logic                       vec_req_valid_o,
  output vec_front_pkg::vec_req_t    vec_req_o,
  input  logic                       vec_req_ready_i
);

  logic                      push;
  vec_front_pkg::buf_entry_t entry;
  logic                      buf_full;
  logic                      head_valid;
  vec_front_pkg::buf_entry_t head;
  logic                      head_ready;
  logic                      vsetvli_done;

  vec_issue_decoder i_decoder (
    .clk_i         (clk_i        ),
    .rst_ni        (rst_ni       ),
    .issue_req_i   (issue_req_i  ),
    .commit_i      (commit_i     ),
    .buf_full_i    (buf_full     ),
    .vsetvli_done_i(vsetvli_done ),
    .issue_ready_o (issue_ready_o),
    .issue_resp_o  (issue_resp_o ),
    .push_o        (push         ),
    .entry_o       (entry        )
  );

  vec_ring_buffer i_ring_buffer (
    .clk_i       (clk_i     ),
    .rst_ni      (rst_ni    ),
    .push_i      (push      ),
    .entry_i     (entry     ),
    .commit_i    (commit_i  ),
    .reg_i       (reg_i     ),
    .full_o      (buf_full  ),
    .head_valid_o(head_valid),
    .head_o      (head      ),
    .head_ready_i(head_ready)
  );

  vec_dispatcher i_dispatcher (
    .clk_i          (clk_i          ),
    .rst_ni         (rst_ni         ),
    .head_valid_i   (head_valid     ),
    .head_i         (head           ),
    .head_ready_o   (head_ready     ),
    .vsetvli_done_o (vsetvli_done   ),
    .result_o       (result_o       ),
    .vec_req_valid_o(vec_req_valid_o),
    .vec_req_o      (vec_req_o      ),
    .vec_req_ready_i(vec_req_ready_i)
  );

endmodule

/* vec_front_pkg.sv */
// Shared types for the vector front end; VLen must be a power of two and at least 64, no LMUL
package vec_front_pkg;

  ////////////////////////////////////////////////////////////
  // Sizes
  ////////////////////////////////////////////////////////////

  localparam int unsigned XLen        = 32;
  localparam int unsigned IdWidth     = 4;
  localparam int unsigned BufDepth    = 8;
  localparam int unsigned BufPtrWidth = $clog2(BufDepth);
  localparam int unsigned VLen        = 256;
  localparam int unsigned VlWidth     = 9;

  // RVV encoding fields
  localparam logic [6:0] OpcodeOpV   = 7'b1010111;
  localparam logic [2:0] Funct3Opivv = 3'd0;
  localparam logic [2:0] Funct3Opmvv = 3'd2;
  localparam logic [2:0] Funct3Cfg   = 3'd7;
  localparam logic [5:0] Funct6Vadd  = 6'd0;
  localparam logic [5:0] Funct6Vmul  = 6'd37;

  typedef logic [VlWidth-1:0]     vl_t;
  typedef logic [IdWidth-1:0]     id_t;
  typedef logic [XLen-1:0]        xlen_t;
  typedef logic [4:0]             reg_idx_t;
  // Extra wrap bit tells full from empty
  typedef logic [BufPtrWidth:0]   buf_ptr_t;
  typedef logic [BufPtrWidth-1:0] buf_idx_t;

  typedef enum logic [1:0] {
    OpVsetvli,
    OpVadd,
    OpVmul,
    OpIllegal
  } vec_op_e;

  // Same code points as the vsew field
  typedef enum logic [1:0] {
    Sew8  = 2'd0,
    Sew16 = 2'd1,
    Sew32 = 2'd2,
    Sew64 = 2'd3
  } sew_e;

  ////////////////////////////////////////////////////////////
  // Stage payloads
  ////////////////////////////////////////////////////////////

  typedef struct packed {logic valid; logic [31:0] instr; id_t id;} issue_req_t;
  typedef struct packed {logic accept; logic writeback;} issue_resp_t;
  typedef struct packed {logic valid; logic kill;} commit_t;
  typedef struct packed {logic valid; id_t id; xlen_t rs1; xlen_t rs2;} reg_t;
  typedef struct packed {logic valid; id_t id; reg_idx_t rd; xlen_t data;} result_t;

  typedef struct packed {
    vec_op_e  op;
    id_t      id;
    reg_idx_t rd;
    reg_idx_t vs1;
    reg_idx_t vs2;
    sew_e     sew;
    xlen_t    rs1;
    xlen_t    rs2;
  } buf_entry_t;

  typedef struct packed {
    vec_op_e  op;
    reg_idx_t vd;
    reg_idx_t vs1;
    reg_idx_t vs2;
    vl_t      vl;
    sew_e     sew;
    xlen_t    rs1;
  } vec_req_t;

endpackage

/* vec_issue_decoder.sv */
// Decodes vsetvli, vadd.vv and vmul.vv only; vsew bit 2 is ignored, so reserved widths alias
`timescale 1ns/1ps

module vec_issue_decoder (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  vec_front_pkg::issue_req_t  issue_req_i,
  input  vec_front_pkg::commit_t     commit_i,
  input  logic                       buf_full_i,
  input  logic                       vsetvli_done_i,
  output logic                       issue_ready_o,
  output vec_front_pkg::issue_resp_t issue_resp_o,
  output logic                       push_o,
  output vec_front_pkg::buf_entry_t  entry_o
);

  logic [31:0]            instr;
  logic [6:0]             opcode;
  logic [2:0]             funct3;
  logic [5:0]             funct6;
  vec_front_pkg::vec_op_e op;
  logic                   kill;
  logic                   stall_d, stall_q;

  assign instr  = issue_req_i.instr;
  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign funct6 = instr[31:26];

  ////////////////////////////////////////////////////////////
  // Decode
  ////////////////////////////////////////////////////////////

  always_comb begin : decode
    op = vec_front_pkg::OpIllegal;
    if (opcode == vec_front_pkg::OpcodeOpV) begin
      if (funct3 == vec_front_pkg::Funct3Cfg && !instr[31]) begin
        op = vec_front_pkg::OpVsetvli;
      end else if (funct3 == vec_front_pkg::Funct3Opivv && funct6 == vec_front_pkg::Funct6Vadd) begin
        op = vec_front_pkg::OpVadd;
      end else if (funct3 == vec_front_pkg::Funct3Opmvv && funct6 == vec_front_pkg::Funct6Vmul) begin
        op = vec_front_pkg::OpVmul;
      end
    end
  end

  // Operand slots stay empty until the core sends registers
  always_comb begin : build_entry
    entry_o     = '0;
    entry_o.op  = op;
    entry_o.id  = issue_req_i.id;
    entry_o.rd  = instr[11:7];
    entry_o.vs1 = instr[19:15];
    entry_o.vs2 = instr[24:20];
    // vsew sits in zimm[5:3]
    entry_o.sew = vec_front_pkg::sew_e'(instr[24:23]);
  end

  ////////////////////////////////////////////////////////////
  // Handshake
  ////////////////////////////////////////////////////////////

  assign kill = commit_i.valid && commit_i.kill;

  assign issue_ready_o          = !buf_full_i && !stall_q && !kill;
  assign issue_resp_o.accept    = issue_req_i.valid && (op != vec_front_pkg::OpIllegal);
  assign issue_resp_o.writeback = issue_req_i.valid && (op == vec_front_pkg::OpVsetvli);
  assign push_o                 = issue_req_i.valid && issue_ready_o && issue_resp_o.accept;

  // Stall from vsetvli acceptance until its result leaves
  always_comb begin : stall_next
    stall_d = stall_q;
    if (vsetvli_done_i) begin
      stall_d = 1'b0;
    end
    // A fresh vsetvli outranks the done of an older one
    if (push_o && op == vec_front_pkg::OpVsetvli) begin
      stall_d = 1'b1;
    end
    if (kill) begin
      stall_d = 1'b0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : stall_reg
    if (!rst_ni) begin
      stall_q <= 1'b0;
    end else begin
      stall_q <= stall_d;
    end
  end

endmodule

/* vec_ring_buffer.sv */
// In-order buffer; commits hit the oldest uncommitted entry and live ids must be unique
`timescale 1ns/1ps

module vec_ring_buffer (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      push_i,
  input  vec_front_pkg::buf_entry_t entry_i,
  input  vec_front_pkg::commit_t    commit_i,
  input  vec_front_pkg::reg_t       reg_i,
  output logic                      full_o,
  output logic                      head_valid_o,
  output vec_front_pkg::buf_entry_t head_o,
  input  logic                      head_ready_i
);

  vec_front_pkg::buf_entry_t               mem_q [vec_front_pkg::BufDepth];
  logic [vec_front_pkg::BufDepth-1:0]      opnd_valid_q;
  vec_front_pkg::buf_ptr_t                 rd_ptr_q, cm_ptr_q, wr_ptr_q;
  vec_front_pkg::buf_ptr_t                 count;
  vec_front_pkg::buf_idx_t                 rd_idx, wr_idx;
  logic [vec_front_pkg::BufDepth-1:0]      live;
  logic [vec_front_pkg::BufDepth-1:0]      reg_hit;
  logic                                    reg_on_push;
  vec_front_pkg::buf_entry_t               push_entry;
  logic                                    kill, commit, pop;

  assign rd_idx = rd_ptr_q[vec_front_pkg::BufPtrWidth-1:0];
  assign wr_idx = wr_ptr_q[vec_front_pkg::BufPtrWidth-1:0];
  assign count  = wr_ptr_q - rd_ptr_q;
  assign full_o = (count == vec_front_pkg::buf_ptr_t'(vec_front_pkg::BufDepth));

  ////////////////////////////////////////////////////////////
  // Commit, kill and head
  ////////////////////////////////////////////////////////////

  assign kill = commit_i.valid && commit_i.kill;
  // A commit may arrive in the same cycle as its own issue
  assign commit = commit_i.valid && !commit_i.kill && ((cm_ptr_q != wr_ptr_q) || push_i);

  // Head needs a commit and its operands
  assign head_valid_o = (rd_ptr_q != cm_ptr_q) && opnd_valid_q[rd_idx];
  assign head_o       = mem_q[rd_idx];
  assign pop          = head_valid_o && head_ready_i;

  ////////////////////////////////////////////////////////////
  // Operand capture
  ////////////////////////////////////////////////////////////

  always_comb begin : match_regs
    for (int unsigned i = 0; i < vec_front_pkg::BufDepth; i++) begin
      live[i]    = {1'b0, vec_front_pkg::buf_idx_t'(i) - rd_idx} < count;
      reg_hit[i] = reg_i.valid && live[i] && !opnd_valid_q[i] && (mem_q[i].id == reg_i.id);
    end
  end

  // Registers racing their own push land directly
  assign reg_on_push = reg_i.valid && push_i && (entry_i.id == reg_i.id);

  always_comb begin : merge_push
    push_entry = entry_i;
    if (reg_on_push) begin
      push_entry.rs1 = reg_i.rs1;
      push_entry.rs2 = reg_i.rs2;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : pointers
    if (!rst_ni) begin
      rd_ptr_q <= '0;
      cm_ptr_q <= '0;
      wr_ptr_q <= '0;
    end else begin
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      if (commit) begin
        cm_ptr_q <= cm_ptr_q + 1'b1;
      end
      // Flush drops everything past the commit point
      if (kill) begin
        wr_ptr_q <= cm_ptr_q;
      end else if (push_i) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : operand_flags
    if (!rst_ni) begin
      opnd_valid_q <= '0;
    end else begin
      for (int unsigned i = 0; i < vec_front_pkg::BufDepth; i++) begin
        if (push_i && !kill && wr_idx == vec_front_pkg::buf_idx_t'(i)) begin
          opnd_valid_q[i] <= reg_on_push;
        end else if (reg_hit[i]) begin
          opnd_valid_q[i] <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin : storage
    for (int unsigned i = 0; i < vec_front_pkg::BufDepth; i++) begin
      if (push_i && wr_idx == vec_front_pkg::buf_idx_t'(i)) begin
        mem_q[i] <= push_entry;
      end else if (reg_hit[i]) begin
        mem_q[i].rs1 <= reg_i.rs1;
        mem_q[i].rs2 <= reg_i.rs2;
      end
    end
  end

endmodule
